// File: sources.f
rtl/bmd_pkg.sv
rtl/bmd_rx_engine.sv
rtl/bmd_ep_regs.sv
rtl/bmd_wdma_ctrl.sv
rtl/bmd_tx_engine.sv
rtl/bmd_endpoint.sv
dv/bmd_tb.sv

// File: Bender.yml
package:
  name: bmd_endpoint

sources:
  - rtl/bmd_pkg.sv
  - rtl/bmd_rx_engine.sv
  - rtl/bmd_ep_regs.sv
  - rtl/bmd_wdma_ctrl.sv
  - rtl/bmd_tx_engine.sv
  - rtl/bmd_endpoint.sv
  - target: simulation
    files:
      - dv/bmd_tb.sv

// File: dv/bmd_tb.sv
// Testbench for the bus-master DMA endpoint with a host bus model and a frame-buffer model
`timescale 1ns/1ps
`default_nettype none

module bmd_tb;

    localparam int XY_W = 10;
    localparam int TMO  = 2000;  // Cycles per wait
    localparam logic [1:0] OP_WR  = 2'd0;
    localparam logic [1:0] OP_RD  = 2'd1;
    localparam logic [1:0] OP_BAD = 2'd2;  // Unsupported requests aimed at the index
    localparam bmd_pkg::req_id_t   CMPL_ID  = 16'h0a10;
    localparam bmd_pkg::dma_addr_t DMA_BASE = 40'h12_8765_4320;

    typedef struct packed {
        logic [1:0]        op;
        bmd_pkg::reg_idx_t idx;
        bmd_pkg::dw_t      val;
        bmd_pkg::dw_t      exp;
    } step_t;

    localparam step_t STEPS [15] = '{
        '{OP_RD,  bmd_pkg::REG_STATUS,  32'h0,         32'h0000_0000},
        '{OP_WR,  bmd_pkg::REG_ADDR_LO, 32'h1234_5678, 32'h0},
        '{OP_RD,  bmd_pkg::REG_ADDR_LO, 32'h0,         32'h1234_5678},
        '{OP_WR,  bmd_pkg::REG_ADDR_HI, 32'hffff_ffab, 32'h0},
        '{OP_RD,  bmd_pkg::REG_ADDR_HI, 32'h0,         32'h0000_00ab},
        '{OP_WR,  bmd_pkg::REG_TLP_LEN, 32'h0000_0103, 32'h0},
        '{OP_RD,  bmd_pkg::REG_TLP_LEN, 32'h0,         32'h0000_0003},
        '{OP_WR,  bmd_pkg::REG_TLP_CNT, 32'habcd_0005, 32'h0},
        '{OP_RD,  bmd_pkg::REG_TLP_CNT, 32'h0,         32'h0000_0005},
        '{OP_WR,  3'd6,                 32'hdead_beef, 32'h0},
        '{OP_RD,  3'd6,                 32'h0,         32'h0000_0000},
        '{OP_WR,  bmd_pkg::REG_CTRL,    32'h0000_0000, 32'h0},
        '{OP_RD,  bmd_pkg::REG_CTRL,    32'h0,         32'h0000_0000},
        '{OP_BAD, bmd_pkg::REG_ADDR_LO, 32'hcafe_f00d, 32'h0},
        '{OP_RD,  bmd_pkg::REG_ADDR_LO, 32'h0,         32'h1234_5678}
    };

    logic                 clk;
    logic                 rst_n;
    bmd_pkg::tlp_beat_t   rx;
    logic                 rx_dst_rdy;
    bmd_pkg::tlp_beat_t   tx;
    logic                 tx_dst_rdy;
    logic [XY_W-1:0]      xy_buf_addr;
    bmd_pkg::qw_t         xy_buf_dat;
    logic                 tf_rise;
    logic                 bp_en;
    logic [31:0]          lfsr;
    logic [15:0]          frame_tag;
    bmd_pkg::tlp_beat_t   tx_q[$];
    bmd_pkg::tlp_beat_t   tlp[$];
    // Expected completion of the last read sent
    bmd_pkg::req_id_t     rd_rid;
    logic [7:0]           rd_tag;
    logic [2:0]           rd_tc;
    logic [1:0]           rd_attr;
    logic [6:0]           rd_lower;
    bmd_pkg::dw_t         rd_exp;

    bmd_endpoint #(.XY_ADDR_W(XY_W)) dut_i (
        .clk                  (clk),
        .rst_n                (rst_n),
        .rx_i                 (rx),
        .rx_dst_rdy_o         (rx_dst_rdy),
        .tx_o                 (tx),
        .tx_dst_rdy_i         (tx_dst_rdy),
        .completer_id_i       (CMPL_ID),
        .xy_buf_addr_o        (xy_buf_addr),
        .xy_buf_dat_i         (xy_buf_dat),
        .timeframe_end_rise_i (tf_rise)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic bmd_pkg::qw_t buf_word(input logic [XY_W-1:0] a, input logic [15:0] tag);
        return {tag, 6'h2c, a, ~a, 12'h5a5, a};
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    always @(posedge clk) begin
        xy_buf_dat <= buf_word(xy_buf_addr, frame_tag);  // One cycle read latency
    end

    always @(negedge clk) begin
        if (bp_en) begin
            tx_dst_rdy <= lfsr[31] | lfsr[30];  // Low about one cycle in four
            lfsr       <= lfsr_step(lfsr_step(lfsr));
        end else begin
            tx_dst_rdy <= 1'b1;
        end
    end

    always @(posedge clk) begin
        if (rst_n && tx.valid && tx_dst_rdy) begin
            tx_q.push_back(tx);
        end
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic compare_beat(input string name, input bmd_pkg::tlp_beat_t got,
                                input bmd_pkg::tlp_beat_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic compare_dw(input string name, input bmd_pkg::dw_t got,
                              input bmd_pkg::dw_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic compare_addr(input string name, input bmd_pkg::dma_addr_t got,
                                input bmd_pkg::dma_addr_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    function automatic bmd_pkg::qw_t req_hdr(input logic [6:0] fmt, input bmd_pkg::tlp_len_t len,
                                             input logic [2:0] tc, input logic [1:0] attr,
                                             input bmd_pkg::req_id_t rid, input logic [7:0] tag);
        return {1'b0, fmt, 1'b0, tc, 6'h00, attr, 2'b00, len, rid, tag, 8'h0f};
    endfunction

    function automatic bmd_pkg::dw_t reg_addr(input bmd_pkg::reg_idx_t idx, input logic [1:0] lo);
        return {24'hf70000, 1'b0, lo, idx, 2'b00};
    endfunction

    task automatic rx_beat(input bmd_pkg::qw_t data, input logic sof, input logic eof);
        int n;
        n = 0;
        @(negedge clk);
        rx = '{sof: sof, eof: eof, valid: 1'b1, data: data};
        @(posedge clk);
        while (!rx_dst_rdy) begin
            n++;
            if (n > TMO) fail_run("Timeout waiting for the endpoint to accept a request beat");
            @(posedge clk);
        end
    endtask

    task automatic send_tlp(input bmd_pkg::qw_t b0, input bmd_pkg::qw_t b1,
                            input bmd_pkg::qw_t b2, input int nbeats);
        rx_beat(b0, 1'b1, 1'b0);
        rx_beat(b1, 1'b0, nbeats == 2);
        if (nbeats == 3) rx_beat(b2, 1'b0, 1'b1);
        @(negedge clk);
        rx = '0;
    endtask

    task automatic host_write(input bmd_pkg::reg_idx_t idx, input bmd_pkg::dw_t val, input int seq);
        send_tlp(req_hdr(bmd_pkg::FMT_MWR3, 10'd1, 3'd0, 2'd0, 16'h0100, 8'(seq)),
                 {reg_addr(idx, 2'd0), val}, '0, 2);
    endtask

    task automatic send_read(input bmd_pkg::reg_idx_t idx, input bmd_pkg::dw_t exp, input int seq);
        rd_rid   = 16'h0100 + 16'(seq);
        rd_tag   = 8'(seq * 7 + 3);
        rd_tc    = 3'(seq);
        rd_attr  = 2'(seq >> 1);
        rd_lower = {2'(seq), idx, 2'b00};
        rd_exp   = exp;
        send_tlp(req_hdr(bmd_pkg::FMT_MRD3, 10'd1, rd_tc, rd_attr, rd_rid, rd_tag),
                 {reg_addr(idx, 2'(seq)), 32'h0}, '0, 2);
    endtask

    // IO write, two-DW write and two-DW read
    task automatic send_unsupported(input bmd_pkg::reg_idx_t idx, input bmd_pkg::dw_t val,
                                    input int seq);
        send_tlp(req_hdr(7'b10_00010, 10'd1, 3'd0, 2'd0, 16'h0100, 8'(seq)),
                 {reg_addr(idx, 2'd0), val}, '0, 2);
        send_tlp(req_hdr(bmd_pkg::FMT_MWR3, 10'd2, 3'd0, 2'd0, 16'h0100, 8'(seq)),
                 {reg_addr(idx, 2'd0), val}, {~val, val}, 3);
        send_tlp(req_hdr(bmd_pkg::FMT_MRD3, 10'd2, 3'd0, 2'd0, 16'h0100, 8'(seq)),
                 {reg_addr(idx, 2'd0), 32'h0}, '0, 2);
    endtask

    task automatic take_tlp();
        int n;
        n = 0;
        tlp.delete();
        while (tlp.size() == 0 || !tlp[$].eof) begin
            if (tx_q.size() > 0) begin
                tlp.push_back(tx_q.pop_front());
            end else begin
                n++;
                if (n > TMO) fail_run("Timeout waiting for a TLP on the transmit stream");
                @(negedge clk);
            end
        end
    endtask

    task automatic check_cpl();
        bmd_pkg::tlp_beat_t exp0;
        bmd_pkg::tlp_beat_t exp1;
        exp0 = '{sof: 1'b1, eof: 1'b0, valid: 1'b1,
                 data: {1'b0, bmd_pkg::FMT_CPLD, 1'b0, rd_tc, 6'h00, rd_attr, 2'b00, 10'd1,
                        CMPL_ID, 3'b000, 1'b0, 12'd4}};
        exp1 = '{sof: 1'b0, eof: 1'b1, valid: 1'b1,
                 data: {rd_rid, rd_tag, 1'b0, rd_lower, rd_exp}};
        if (tlp.size() != 2) begin
            fail_run($sformatf("Completion arrived with %0d beats instead of 2", tlp.size()));
        end
        compare_beat("cpl beat 0", tlp[0], exp0);
        compare_dw("cpl data", tlp[1].data[31:0], rd_exp);
        compare_beat("cpl beat 1", tlp[1], exp1);
    endtask

    task automatic read_check(input bmd_pkg::reg_idx_t idx, input bmd_pkg::dw_t exp, input int seq);
        send_read(idx, exp, seq);
        if (rx_dst_rdy !== 1'b0) begin
            fail_run("Receive ready stayed high while a completion was pending");
        end
        take_tlp();
        check_cpl();
        if (rx_dst_rdy !== 1'b1) begin
            fail_run("Receive ready did not return after the completion was sent");
        end
    endtask

    task automatic check_mwr(input bmd_pkg::dma_addr_t addr, input int len, input int ofs);
        bmd_pkg::tlp_beat_t exp;
        int j;
        if (tlp.size() != len + 2) begin
            fail_run($sformatf("Write TLP has %0d beats, expected %0d", tlp.size(), len + 2));
        end
        exp = '{sof: 1'b1, eof: 1'b0, valid: 1'b1,
                data: {1'b0, bmd_pkg::FMT_MWR4, 1'b0, 3'd0, 6'h00, 2'b00, 2'b00, 10'(2 * len),
                       CMPL_ID, 8'h00, 8'hff}};
        compare_beat("mwr header", tlp[0], exp);
        compare_addr("mwr address", {tlp[1].data[39:32], tlp[1].data[31:0]}, addr);
        exp = '{sof: 1'b0, eof: 1'b0, valid: 1'b1, data: {24'h0, addr[39:32], addr[31:0]}};
        compare_beat("mwr address beat", tlp[1], exp);
        for (j = 0; j < len; j++) begin
            exp = '{sof: 1'b0, eof: j == len - 1, valid: 1'b1,
                    data: buf_word(XY_W'(ofs + j), frame_tag)};
            compare_beat($sformatf("mwr payload %0d", j), tlp[j + 2], exp);
        end
    endtask

    // One frame of writes, optionally with one completion between them
    task automatic expect_frame(input int len, input int cnt, input logic with_cpl);
        int k;
        logic cpl_seen;
        k = 0;
        cpl_seen = 1'b0;
        while (k < cnt || (with_cpl && !cpl_seen)) begin
            take_tlp();
            if (tlp[0].data[62:56] == bmd_pkg::FMT_CPLD) begin
                if (!with_cpl || cpl_seen) fail_run("Unexpected completion during a DMA frame");
                if (k == 0 || k == cnt) fail_run("Completion was not sent between two write TLPs");
                check_cpl();
                cpl_seen = 1'b1;
            end else begin
                check_mwr(DMA_BASE + bmd_pkg::dma_addr_t'(k * len * 8), len, k * len);
                k++;
            end
        end
    endtask

    task automatic expect_quiet(input int cycles, input string what);
        repeat (cycles) @(negedge clk);
        if (tx_q.size() != 0) begin
            fail_run($sformatf("Unexpected transmit beats after %s", what));
        end
    endtask

    task automatic pulse_tf();
        @(negedge clk);
        tf_rise = 1'b1;
        @(negedge clk);
        tf_rise = 1'b0;
    endtask

    initial begin
        int i;
        step_t s;
        rst_n      = 1'b0;
        rx         = '0;
        tx_dst_rdy = 1'b1;
        tf_rise    = 1'b0;
        bp_en      = 1'b0;
        lfsr       = 32'h40d61f78;
        frame_tag  = 16'h0000;
        xy_buf_dat = '0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        if (rx_dst_rdy !== 1'b1) begin
            fail_run("Receive ready is not high after reset");
        end

        for (i = 0; i < 15; i++) begin
            s = STEPS[i];
            case (s.op)
                OP_WR: host_write(s.idx, s.val, i);
                OP_RD: read_check(s.idx, s.exp, i);
                default: begin
                    send_unsupported(s.idx, s.val, i);
                    expect_quiet(20, "unsupported requests");
                end
            endcase
        end

        host_write(bmd_pkg::REG_ADDR_LO, DMA_BASE[31:0], 20);
        host_write(bmd_pkg::REG_ADDR_HI, 32'(DMA_BASE[39:32]), 21);
        host_write(bmd_pkg::REG_TLP_LEN, 32'd3, 22);
        host_write(bmd_pkg::REG_TLP_CNT, 32'd4, 23);
        host_write(bmd_pkg::REG_CTRL, 32'h1, 24);
        read_check(bmd_pkg::REG_STATUS, 32'h0000_0001, 25);
        bp_en = 1'b1;

        frame_tag = 16'hf001;
        pulse_tf();
        expect_frame(3, 4, 1'b0);
        read_check(bmd_pkg::REG_STATUS, 32'h0001_0001, 26);

        // Read in flight and a second edge while busy
        frame_tag = 16'hf002;
        pulse_tf();
        send_read(bmd_pkg::REG_TLP_LEN, 32'd3, 27);
        pulse_tf();
        expect_frame(3, 4, 1'b1);
        expect_quiet(60, "the second frame");
        read_check(bmd_pkg::REG_STATUS, 32'h0002_0001, 28);

        // Stop lands mid-frame, the frame still completes
        frame_tag = 16'hf003;
        pulse_tf();
        host_write(bmd_pkg::REG_CTRL, 32'h2, 29);
        expect_frame(3, 4, 1'b0);
        read_check(bmd_pkg::REG_STATUS, 32'h0003_0000, 30);
        pulse_tf();
        expect_quiet(60, "a time-frame edge while stopped");
        read_check(bmd_pkg::REG_STATUS, 32'h0003_0000, 31);
        expect_quiet(20, "the last read");

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/bmd_endpoint.sv
// Bus-master DMA endpoint top joining the receive, register, DMA and transmit blocks
`timescale 1ns/1ps
`default_nettype none

module bmd_endpoint #(
    parameter int XY_ADDR_W = 10
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  bmd_pkg::tlp_beat_t   rx_i,
    output logic                 rx_dst_rdy_o,
    output bmd_pkg::tlp_beat_t   tx_o,
    input  logic                 tx_dst_rdy_i,
    input  bmd_pkg::req_id_t     completer_id_i,
    output logic [XY_ADDR_W-1:0] xy_buf_addr_o,
    input  bmd_pkg::qw_t         xy_buf_dat_i,
    input  logic                 timeframe_end_rise_i
);

    bmd_pkg::reg_wr_t  reg_wr;
    bmd_pkg::cpl_req_t cpl_req;
    logic              cpl_pend;
    logic              cpl_done;
    bmd_pkg::dw_t      rd_data;
    bmd_pkg::dma_cfg_t dma_cfg;
    logic              dma_start;
    logic              dma_stop;
    logic              dma_armed;
    logic              dma_busy;
    logic [15:0]       frames_done;
    logic              mwr_start;
    logic              mwr_done;
    bmd_pkg::dma_req_t mwr_req;

    bmd_rx_engine rx_engine_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .rx_i         (rx_i),
        .cpl_done_i   (cpl_done),
        .rx_dst_rdy_o (rx_dst_rdy_o),
        .reg_wr_o     (reg_wr),
        .cpl_req_o    (cpl_req),
        .cpl_pend_o   (cpl_pend)
    );

    bmd_ep_regs ep_regs_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .reg_wr_i      (reg_wr),
        .rd_idx_i      (cpl_req.idx),  // Read index follows the pending request
        .dma_armed_i   (dma_armed),
        .dma_busy_i    (dma_busy),
        .frames_done_i (frames_done),
        .rd_data_o     (rd_data),
        .dma_cfg_o     (dma_cfg),
        .dma_start_o   (dma_start),
        .dma_stop_o    (dma_stop)
    );

    bmd_wdma_ctrl #(.XY_ADDR_W(XY_ADDR_W)) wdma_ctrl_i (
        .clk                  (clk),
        .rst_n                (rst_n),
        .dma_cfg_i            (dma_cfg),
        .dma_start_i          (dma_start),
        .dma_stop_i           (dma_stop),
        .timeframe_end_rise_i (timeframe_end_rise_i),
        .mwr_done_i           (mwr_done),
        .mwr_start_o          (mwr_start),
        .mwr_req_o            (mwr_req),
        .dma_armed_o          (dma_armed),
        .dma_busy_o           (dma_busy),
        .frames_done_o        (frames_done)
    );

    bmd_tx_engine #(.XY_ADDR_W(XY_ADDR_W)) tx_engine_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .tx_dst_rdy_i   (tx_dst_rdy_i),
        .completer_id_i (completer_id_i),
        .cpl_pend_i     (cpl_pend),
        .cpl_req_i      (cpl_req),
        .rd_data_i      (rd_data),
        .mwr_start_i    (mwr_start),
        .mwr_req_i      (mwr_req),
        .xy_buf_dat_i   (xy_buf_dat_i),
        .tx_o           (tx_o),
        .cpl_done_o     (cpl_done),
        .mwr_done_o     (mwr_done),
        .xy_buf_addr_o  (xy_buf_addr_o)
    );

endmodule

`default_nettype wire

// File: rtl/bmd_tx_engine.sv
// Transmit engine that builds completions and 4DW write TLPs onto one stream
`timescale 1ns/1ps
`default_nettype none

module bmd_tx_engine #(
    parameter int XY_ADDR_W = 10
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 tx_dst_rdy_i,
    input  bmd_pkg::req_id_t     completer_id_i,
    input  logic                 cpl_pend_i,
    input  bmd_pkg::cpl_req_t    cpl_req_i,
    input  bmd_pkg::dw_t         rd_data_i,
    input  logic                 mwr_start_i,
    input  bmd_pkg::dma_req_t    mwr_req_i,
    input  bmd_pkg::qw_t         xy_buf_dat_i,
    output bmd_pkg::tlp_beat_t   tx_o,
    output logic                 cpl_done_o,
    output logic                 mwr_done_o,
    output logic [XY_ADDR_W-1:0] xy_buf_addr_o
);

    bmd_pkg::tx_state_e state_q;
    bmd_pkg::qw_t       hdr_q;
    bmd_pkg::dma_req_t  req_q;
    logic               mwr_pend_q;
    logic [7:0]         qw_cnt_q;
    logic               last_qw;
    bmd_pkg::tlp_len_t  mwr_len;
    bmd_pkg::dw_t       cpl_dw0;
    bmd_pkg::dw_t       cpl_dw1;
    bmd_pkg::dw_t       cpl_dw2;
    bmd_pkg::dw_t       mwr_dw0;
    bmd_pkg::dw_t       mwr_dw1;

    assign last_qw = qw_cnt_q == req_q.len_qw - 8'd1;
    assign mwr_len = {1'b0, req_q.len_qw, 1'b0};  // Two DWs per qword

    assign cpl_dw0 = {1'b0, bmd_pkg::FMT_CPLD, 1'b0, cpl_req_i.tc, 6'h00, cpl_req_i.attr,
                      2'b00, 10'd1};
    assign cpl_dw1 = {completer_id_i, 3'b000, 1'b0, 12'd4};  // Status SC, 4 bytes
    assign cpl_dw2 = {cpl_req_i.rid, cpl_req_i.tag, 1'b0, cpl_req_i.lower_addr};
    assign mwr_dw0 = {1'b0, bmd_pkg::FMT_MWR4, 14'h0, mwr_len};
    assign mwr_dw1 = {completer_id_i, 8'h00, 8'hff};  // Tag 0, all byte enables

    assign xy_buf_addr_o = XY_ADDR_W'(req_q.buf_ofs) + XY_ADDR_W'(qw_cnt_q);
    assign cpl_done_o    = state_q == bmd_pkg::TX_CPL_DAT && tx_dst_rdy_i;
    assign mwr_done_o    = state_q == bmd_pkg::TX_MWR_DATA && tx_dst_rdy_i && last_qw;

    // Payload comes straight from the buffer, which holds while the address holds
    always_comb begin
        tx_o.sof   = state_q == bmd_pkg::TX_CPL_HDR || state_q == bmd_pkg::TX_MWR_HDR0;
        tx_o.eof   = state_q == bmd_pkg::TX_CPL_DAT || (state_q == bmd_pkg::TX_MWR_DATA && last_qw);
        tx_o.valid = state_q != bmd_pkg::TX_IDLE && state_q != bmd_pkg::TX_MWR_FETCH;
        tx_o.data  = state_q == bmd_pkg::TX_MWR_DATA ? xy_buf_dat_i : hdr_q;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= bmd_pkg::TX_IDLE;
            mwr_pend_q <= 1'b0;
        end else begin
            if (mwr_start_i) begin
                mwr_pend_q <= 1'b1;
            end
            case (state_q)
                bmd_pkg::TX_IDLE: begin
                    if (cpl_pend_i) begin
                        state_q <= bmd_pkg::TX_CPL_HDR;  // Completion first
                    end else if (mwr_pend_q) begin
                        mwr_pend_q <= 1'b0;
                        state_q    <= bmd_pkg::TX_MWR_HDR0;
                    end
                end
                bmd_pkg::TX_CPL_HDR: if (tx_dst_rdy_i) state_q <= bmd_pkg::TX_CPL_DAT;
                bmd_pkg::TX_CPL_DAT: if (tx_dst_rdy_i) state_q <= bmd_pkg::TX_IDLE;
                bmd_pkg::TX_MWR_HDR0: if (tx_dst_rdy_i) state_q <= bmd_pkg::TX_MWR_HDR1;
                bmd_pkg::TX_MWR_HDR1: if (tx_dst_rdy_i) state_q <= bmd_pkg::TX_MWR_FETCH;
                bmd_pkg::TX_MWR_FETCH: state_q <= bmd_pkg::TX_MWR_DATA;
                default: begin
                    if (tx_dst_rdy_i) begin
                        state_q <= last_qw ? bmd_pkg::TX_IDLE : bmd_pkg::TX_MWR_FETCH;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (mwr_start_i) begin
            req_q <= mwr_req_i;
        end
        if (state_q == bmd_pkg::TX_IDLE) begin
            hdr_q    <= cpl_pend_i ? {cpl_dw0, cpl_dw1} : {mwr_dw0, mwr_dw1};
            qw_cnt_q <= '0;
        end
        if (state_q == bmd_pkg::TX_CPL_HDR && tx_dst_rdy_i) begin
            hdr_q <= {cpl_dw2, rd_data_i};  // Register data sampled here
        end
        if (state_q == bmd_pkg::TX_MWR_HDR0 && tx_dst_rdy_i) begin
            hdr_q <= {24'h0, req_q.addr[39:32], req_q.addr[31:2], 2'b00};
        end
        if (state_q == bmd_pkg::TX_MWR_DATA && tx_dst_rdy_i) begin
            qw_cnt_q <= qw_cnt_q + 8'd1;
        end
    end

    // Holds across the frame-buffer read as well
    stall_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
        tx_o.valid && !tx_dst_rdy_i |=> $stable(tx_o));

endmodule

`default_nettype wire

// File: rtl/bmd_wdma_ctrl.sv
// DMA frame controller that issues one frame of write TLPs per time-frame edge
`timescale 1ns/1ps
`default_nettype none

module bmd_wdma_ctrl #(
    parameter int XY_ADDR_W = 10
) (
    input  logic              clk,
    input  logic              rst_n,
    input  bmd_pkg::dma_cfg_t dma_cfg_i,
    input  logic              dma_start_i,
    input  logic              dma_stop_i,
    input  logic              timeframe_end_rise_i,
    input  logic              mwr_done_i,
    output logic              mwr_start_o,
    output bmd_pkg::dma_req_t mwr_req_o,
    output logic              dma_armed_o,
    output logic              dma_busy_o,
    output logic [15:0]       frames_done_o
);

    bmd_pkg::dma_state_e  state_q;
    bmd_pkg::dma_addr_t   addr_q;
    logic [XY_ADDR_W-1:0] ofs_q;
    logic [7:0]           len_q;
    logic [15:0]          cnt_q;
    logic [15:0]          tlp_idx_q;
    logic                 stop_pend_q;
    logic                 frame_go;
    logic                 last_tlp;

    assign frame_go    = state_q == bmd_pkg::DMA_ARMED && timeframe_end_rise_i && !dma_stop_i
                         && dma_cfg_i.tlp_cnt != 16'd0;
    assign last_tlp    = tlp_idx_q == cnt_q - 16'd1;
    assign mwr_start_o = state_q == bmd_pkg::DMA_ISSUE;
    assign dma_armed_o = state_q != bmd_pkg::DMA_IDLE;
    assign dma_busy_o  = state_q == bmd_pkg::DMA_ISSUE || state_q == bmd_pkg::DMA_WAIT_DONE;

    assign mwr_req_o = '{addr: addr_q, len_qw: len_q, buf_ofs: 16'(ofs_q)};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q       <= bmd_pkg::DMA_IDLE;
            stop_pend_q   <= 1'b0;
            frames_done_o <= '0;
        end else begin
            if (dma_stop_i && dma_busy_o) begin
                stop_pend_q <= 1'b1;  // Honoured at the end of the frame
            end
            case (state_q)
                bmd_pkg::DMA_IDLE: begin
                    if (dma_start_i) begin
                        state_q <= bmd_pkg::DMA_ARMED;
                    end
                end
                bmd_pkg::DMA_ARMED: begin
                    if (dma_stop_i) begin
                        state_q <= bmd_pkg::DMA_IDLE;
                    end else if (frame_go) begin
                        state_q <= bmd_pkg::DMA_ISSUE;
                    end
                end
                bmd_pkg::DMA_ISSUE: state_q <= bmd_pkg::DMA_WAIT_DONE;
                default: begin
                    if (mwr_done_i && !last_tlp) begin
                        state_q <= bmd_pkg::DMA_ISSUE;
                    end else if (mwr_done_i) begin
                        frames_done_o <= frames_done_o + 16'd1;
                        stop_pend_q   <= 1'b0;
                        state_q <= (stop_pend_q || dma_stop_i) ? bmd_pkg::DMA_IDLE
                                                               : bmd_pkg::DMA_ARMED;
                    end
                end
            endcase
        end
    end

    // Frame snapshot and per-TLP stepping
    always_ff @(posedge clk) begin
        if (frame_go) begin
            addr_q    <= dma_cfg_i.base;
            ofs_q     <= '0;
            len_q     <= dma_cfg_i.len_qw;
            cnt_q     <= dma_cfg_i.tlp_cnt;
            tlp_idx_q <= '0;
        end else if (state_q == bmd_pkg::DMA_WAIT_DONE && mwr_done_i) begin
            addr_q    <= addr_q + bmd_pkg::dma_addr_t'({len_q, 3'b000});  // Len x 8 bytes
            ofs_q     <= ofs_q + XY_ADDR_W'(len_q);
            tlp_idx_q <= tlp_idx_q + 16'd1;
        end
    end

    // A write TLP can only finish while one is outstanding
    one_outstanding_a: assert property (@(posedge clk) disable iff (!rst_n)
        mwr_done_i |-> state_q == bmd_pkg::DMA_WAIT_DONE);

endmodule

`default_nettype wire

// File: rtl/bmd_ep_regs.sv
// Endpoint register file holding the DMA configuration and giving start and stop pulses
`timescale 1ns/1ps
`default_nettype none

module bmd_ep_regs (
    input  logic              clk,
    input  logic              rst_n,
    input  bmd_pkg::reg_wr_t  reg_wr_i,
    input  bmd_pkg::reg_idx_t rd_idx_i,
    input  logic              dma_armed_i,
    input  logic              dma_busy_i,
    input  logic [15:0]       frames_done_i,
    output bmd_pkg::dw_t      rd_data_o,
    output bmd_pkg::dma_cfg_t dma_cfg_o,
    output logic              dma_start_o,
    output logic              dma_stop_o
);

    bmd_pkg::dw_t addr_lo_q;
    logic [7:0]   addr_hi_q;
    logic [7:0]   tlp_len_q;
    logic [15:0]  tlp_cnt_q;
    logic         wr_ctrl;

    assign wr_ctrl = reg_wr_i.valid && reg_wr_i.idx == bmd_pkg::REG_CTRL;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            addr_lo_q   <= '0;
            addr_hi_q   <= '0;
            tlp_len_q   <= '0;
            tlp_cnt_q   <= '0;
            dma_start_o <= 1'b0;
            dma_stop_o  <= 1'b0;
        end else begin
            dma_start_o <= wr_ctrl && reg_wr_i.data[0];
            dma_stop_o  <= wr_ctrl && reg_wr_i.data[1];
            if (reg_wr_i.valid) begin
                case (reg_wr_i.idx)
                    bmd_pkg::REG_ADDR_LO: addr_lo_q <= reg_wr_i.data;
                    bmd_pkg::REG_ADDR_HI: addr_hi_q <= reg_wr_i.data[7:0];  // Bits 39:32
                    bmd_pkg::REG_TLP_LEN: tlp_len_q <= reg_wr_i.data[7:0];
                    bmd_pkg::REG_TLP_CNT: tlp_cnt_q <= reg_wr_i.data[15:0];
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (rd_idx_i)
            bmd_pkg::REG_ADDR_LO: rd_data_o = addr_lo_q;
            bmd_pkg::REG_ADDR_HI: rd_data_o = {24'h0, addr_hi_q};
            bmd_pkg::REG_TLP_LEN: rd_data_o = {24'h0, tlp_len_q};
            bmd_pkg::REG_TLP_CNT: rd_data_o = {16'h0, tlp_cnt_q};
            bmd_pkg::REG_STATUS:  rd_data_o = {frames_done_i, 14'h0, dma_busy_i, dma_armed_i};
            default:              rd_data_o = '0;  // Control is write-only
        endcase
    end

    assign dma_cfg_o = '{base: {addr_hi_q, addr_lo_q}, len_qw: tlp_len_q, tlp_cnt: tlp_cnt_q};

endmodule

`default_nettype wire

// File: rtl/bmd_rx_engine.sv
// Receive engine that turns host TLPs into register writes and completion requests
`timescale 1ns/1ps
`default_nettype none

module bmd_rx_engine (
    input  logic               clk,
    input  logic               rst_n,
    input  bmd_pkg::tlp_beat_t rx_i,
    input  logic               cpl_done_i,
    output logic               rx_dst_rdy_o,
    output bmd_pkg::reg_wr_t   reg_wr_o,
    output bmd_pkg::cpl_req_t  cpl_req_o,
    output logic               cpl_pend_o
);

    bmd_pkg::rx_state_e state_q;
    logic [6:0]         fmt_type_q;
    bmd_pkg::tlp_len_t  len_q;
    logic               beat_acc;
    logic               body_eof;
    logic               is_wr1;
    logic               is_rd1;

    assign rx_dst_rdy_o = !cpl_pend_o;  // Hold off requests until the completion is out
    assign beat_acc     = rx_i.valid && rx_dst_rdy_o;
    assign body_eof     = beat_acc && state_q == bmd_pkg::RX_BODY && rx_i.eof;
    assign is_wr1       = fmt_type_q == bmd_pkg::FMT_MWR3 && len_q == 10'd1;
    assign is_rd1       = fmt_type_q == bmd_pkg::FMT_MRD3 && len_q == 10'd1;

    // Beat 1 of a 3DW write, address high and data low
    always_comb begin
        reg_wr_o.valid = body_eof && is_wr1;
        reg_wr_o.idx   = rx_i.data[36:34];
        reg_wr_o.data  = rx_i.data[31:0];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= bmd_pkg::RX_IDLE;
            cpl_pend_o <= 1'b0;
        end else begin
            if (cpl_done_i) begin
                cpl_pend_o <= 1'b0;
            end
            if (beat_acc) begin
                case (state_q)
                    bmd_pkg::RX_IDLE: begin
                        if (rx_i.sof && !rx_i.eof) begin
                            state_q <= bmd_pkg::RX_BODY;
                        end
                    end
                    bmd_pkg::RX_BODY: begin
                        if (rx_i.eof && is_rd1) begin
                            cpl_pend_o <= 1'b1;
                        end
                        state_q <= rx_i.eof ? bmd_pkg::RX_IDLE : bmd_pkg::RX_DRAIN;
                    end
                    default: begin
                        if (rx_i.eof) begin
                            state_q <= bmd_pkg::RX_IDLE;
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (beat_acc && state_q == bmd_pkg::RX_IDLE && rx_i.sof) begin
            fmt_type_q     <= rx_i.data[62:56];
            len_q          <= rx_i.data[41:32];
            cpl_req_o.tc   <= rx_i.data[54:52];
            cpl_req_o.attr <= rx_i.data[45:44];
            cpl_req_o.rid  <= rx_i.data[31:16];
            cpl_req_o.tag  <= rx_i.data[15:8];
        end
        if (beat_acc && state_q == bmd_pkg::RX_BODY) begin
            cpl_req_o.lower_addr <= rx_i.data[38:32];
            cpl_req_o.idx        <= rx_i.data[36:34];
        end
    end

    // Only a pending completion can be finished by the transmit side
    cpl_done_pend_a: assert property (@(posedge clk) disable iff (!rst_n)
        cpl_done_i |-> cpl_pend_o);

endmodule

`default_nettype wire

// File: rtl/bmd_pkg.sv
// Bus-master DMA endpoint package with TLP field codes, register map, structs and FSM states
`default_nettype none

package bmd_pkg;

    typedef logic [31:0] dw_t;
    typedef logic [63:0] qw_t;
    typedef logic [39:0] dma_addr_t;
    typedef logic [9:0]  tlp_len_t;  // In DWs
    typedef logic [2:0]  reg_idx_t;  // Address bits 4:2
    typedef logic [15:0] req_id_t;

    // fmt[1:0] followed by type[4:0]
    localparam logic [6:0] FMT_MRD3 = 7'b00_00000;
    localparam logic [6:0] FMT_MWR3 = 7'b10_00000;
    localparam logic [6:0] FMT_MWR4 = 7'b11_00000;
    localparam logic [6:0] FMT_CPLD = 7'b10_01010;

    localparam reg_idx_t REG_CTRL    = 3'd0;
    localparam reg_idx_t REG_ADDR_LO = 3'd1;
    localparam reg_idx_t REG_ADDR_HI = 3'd2;
    localparam reg_idx_t REG_TLP_LEN = 3'd3;
    localparam reg_idx_t REG_TLP_CNT = 3'd4;
    localparam reg_idx_t REG_STATUS  = 3'd5;

    typedef struct packed {
        logic sof;
        logic eof;
        logic valid;
        qw_t  data;
    } tlp_beat_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t idx;
        dw_t      data;
    } reg_wr_t;

    typedef struct packed {
        req_id_t    rid;
        logic [7:0] tag;
        logic [2:0] tc;
        logic [1:0] attr;
        logic [6:0] lower_addr;
        reg_idx_t   idx;
    } cpl_req_t;

    typedef struct packed {
        dma_addr_t   base;
        logic [7:0]  len_qw;
        logic [15:0] tlp_cnt;
    } dma_cfg_t;

    typedef struct packed {
        dma_addr_t   addr;
        logic [7:0]  len_qw;
        logic [15:0] buf_ofs;  // Frame-buffer word of the first qword
    } dma_req_t;

    typedef enum logic [1:0] {RX_IDLE, RX_BODY, RX_DRAIN} rx_state_e;

    typedef enum logic [2:0] {
        TX_IDLE, TX_CPL_HDR, TX_CPL_DAT, TX_MWR_HDR0, TX_MWR_HDR1, TX_MWR_FETCH, TX_MWR_DATA
    } tx_state_e;

    typedef enum logic [1:0] {DMA_IDLE, DMA_ARMED, DMA_ISSUE, DMA_WAIT_DONE} dma_state_e;

endpackage

`default_nettype wire
